// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fetch_buffer
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation finished: FAIL

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fetch_buffer_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer_props #(
  parameter int LINE_DEPTH = 4
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           ar_valid_i,
  input  wire                           ar_ready_i,
  input  wire  [31:0]                   ar_addr_i,
  input  wire                           r_valid_i,
  input  wire                           r_ready_i,
  input  wire  fetch_pkg::fetch_state_e state_i,
  input  wire  [$clog2(LINE_DEPTH):0]   count_i
);
  import fetch_pkg::*;

  localparam int CNT_W = $clog2(LINE_DEPTH) + 1;

  int   fail_count = 0;
  logic read_open;

  // opened by the address handshake, closed by the data handshake
  always_ff @(posedge clk) begin
    if (rst_n) begin
      read_open <= 1'b0;
    end else if (ar_valid_i && ar_ready_i) begin
      read_open <= 1'b1;
    end else if (r_valid_i && r_ready_i) begin
      read_open <= 1'b0;
    end
  end

  // address held until the slave takes it
  ar_addr_held: assert property (@(posedge clk) disable iff (rst_n)
    (ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_addr_i)))
    else begin
      fail_count = fail_count + 1;
      $error("ar_addr_o changed or ar_valid_o dropped before the address handshake");
    end

  no_ar_in_data: assert property (@(posedge clk) disable iff (rst_n)
    read_open |-> (!ar_valid_i && (state_i == FETCH_DATA)))
    else begin
      fail_count = fail_count + 1;
      $error("ar_valid_o raised while a read is outstanding");
    end

  count_in_range: assert property (@(posedge clk) disable iff (rst_n)
    count_i <= LINE_DEPTH[CNT_W-1:0])
    else begin
      fail_count = fail_count + 1;
      $error("queue count above LINE_DEPTH");
    end

endmodule

bind line_fetch_ctrl fetch_buffer_props #(.LINE_DEPTH(LINE_DEPTH)) props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_addr_i  (ar_addr_o),
  .r_valid_i  (r_valid_i),
  .r_ready_i  (r_ready_o),
  .state_i    (state),
  .count_i    (q.count)
);

`default_nettype wire

// ==== fetch_buffer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer_top #(
  parameter int          LINE_DEPTH = 4,
  parameter logic [31:0] RESET_PC   = 32'h8000_0000
) (
  input  wire                           clk,
  input  wire                           rst_n,
  // core side
  input  wire  [31:0]                   pc_i,
  input  wire                           jmp_flush_i,
  output logic                          inst_valid_o,
  output logic [fetch_pkg::WORD_BITS:0] inst_o,
  // AXI read address
  output logic                          ar_valid_o,
  input  wire                           ar_ready_i,
  output logic [31:0]                   ar_addr_o,
  // AXI read data
  input  wire                           r_valid_i,
  output logic                          r_ready_o,
  input  wire  fetch_pkg::line_t        r_data_i,
  input  wire  [1:0]                    r_resp_i
);

  line_queue_if #(.LINE_DEPTH(LINE_DEPTH)) lq_if ();

  // ====================================================================
  // request side
  // ====================================================================
  line_fetch_ctrl #(
    .LINE_DEPTH (LINE_DEPTH),
    .RESET_PC   (RESET_PC)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .jmp_flush_i (jmp_flush_i),
    .pc_i        (pc_i),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_addr_o   (ar_addr_o),
    .r_valid_i   (r_valid_i),
    .r_ready_o   (r_ready_o),
    .r_data_i    (r_data_i),
    .r_resp_i    (r_resp_i),
    .q           (lq_if.ctrl)
  );

  line_queue #(
    .LINE_DEPTH (LINE_DEPTH)
  ) u_queue (
    .clk   (clk),
    .rst_n (rst_n),
    .q     (lq_if.queue)
  );

  // ====================================================================
  // core side
  // ====================================================================
  inst_select u_select (
    .pc_i         (pc_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .q            (lq_if.select)
  );

endmodule

`default_nettype wire

// ==== fetch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_checker (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire  [31:0]                  pc_i,
  input  wire                          inst_valid_i,
  input  wire  [fetch_pkg::WORD_BITS:0] inst_i,
  input  wire                          ar_valid_i,
  input  wire                          exp_fault_i,
  input  wire                          idle_expect_i,
  output int                           check_count_o,
  output int                           err_count_o
);
  import fetch_pkg::*;

  localparam logic [31:0] DATA_KEY = 32'h5a5a_0f0f;

  logic [31:0] exp_word;

  // memory rule, word at byte address a is a ^ key
  assign exp_word = {pc_i[31:2], 2'b00} ^ DATA_KEY;

  always @(posedge clk) begin : compare_proc
    int errs;
    errs = 0;
    if (rst_n) begin
      check_count_o <= 0;
      err_count_o   <= 0;
    end else begin
      if (inst_valid_i) begin
        if (inst_i[WORD_BITS-1:0] !== exp_word) begin
          $display("FAIL %0t: pc %h gave word %h, expected %h",
                   $time, pc_i, inst_i[WORD_BITS-1:0], exp_word);
          errs++;
        end
        if (inst_i[WORD_BITS] !== exp_fault_i) begin
          $display("FAIL %0t: pc %h gave fault %b, expected %b",
                   $time, pc_i, inst_i[WORD_BITS], exp_fault_i);
          errs++;
        end
      end
      // queue should be full here, so no new line request
      if (idle_expect_i && ar_valid_i) begin
        $display("FAIL %0t: ar_valid_o high while the queue should be full", $time);
        errs++;
      end
      check_count_o <= check_count_o + (inst_valid_i ? 1 : 0);
      err_count_o   <= err_count_o + errs;
    end
  end

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // ====================================================================
  // line geometry
  // ====================================================================
  localparam int LINE_BITS   = 128;
  localparam int WORD_BITS   = 32;
  localparam int OFFSET_BITS = 4;
  localparam int TAG_BITS    = 32 - OFFSET_BITS;
  localparam int WSEL_BITS   = $clog2(LINE_BITS / WORD_BITS);

  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [TAG_BITS-1:0]  tag_t;

  // one queue slot, 157 bits
  typedef struct packed {
    line_t line;
    tag_t  tag;
    logic  fault;
  } q_entry_t;

  // ====================================================================
  // read channel sequencing
  // ====================================================================
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_ADDR = 2'd1,
    FETCH_DATA = 2'd2
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== filelist.f ====
fetch_pkg.sv
line_queue_if.sv
line_queue.sv
line_fetch_ctrl.sv
inst_select.sv
fetch_buffer_top.sv
fetch_checker.sv
fetch_buffer_props.sv
tb_fetch_buffer.sv

// ==== inst_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_select (
  input  wire  [31:0]                 pc_i,
  output logic                        inst_valid_o,
  output logic [fetch_pkg::WORD_BITS:0] inst_o,
  line_queue_if.select                q
);
  import fetch_pkg::*;

  tag_t           pc_tag;
  q_entry_t       sel_entry;
  logic [WSEL_BITS-1:0] wsel;
  logic [WORD_BITS-1:0] word;
  logic           head_hit;
  logic           bypass_hit;

  assign pc_tag = pc_i[31:OFFSET_BITS];
  assign wsel   = pc_i[OFFSET_BITS-1:2];

  // ====================================================================
  // hit detection
  // ====================================================================
  assign head_hit   = !q.empty && (q.head_entry.tag == pc_tag);

  // response landing in an empty queue goes straight out
  assign bypass_hit = q.empty && q.push && (q.push_entry.tag == pc_tag);

  // head no longer matches the pc line, drop it
  assign q.pop = !q.empty && (q.head_entry.tag != pc_tag);

  assign inst_valid_o = head_hit || bypass_hit;

  // ====================================================================
  // word mux
  // ====================================================================
  always_comb begin
    if (q.empty) begin
      sel_entry = q.push_entry;
    end else begin
      sel_entry = q.head_entry;
    end
  end

  always_comb begin
    case (wsel)
      2'd0:    word = sel_entry.line[31:0];
      2'd1:    word = sel_entry.line[63:32];
      2'd2:    word = sel_entry.line[95:64];
      default: word = sel_entry.line[127:96];
    endcase
  end

  // fault rides on top of the word
  assign inst_o = {sel_entry.fault, word};

endmodule

`default_nettype wire

// ==== line_fetch_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_fetch_ctrl #(
  parameter int          LINE_DEPTH = 4,
  parameter logic [31:0] RESET_PC   = 32'h8000_0000
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    jmp_flush_i,
  input  wire  [31:0]            pc_i,
  output logic                   ar_valid_o,
  input  wire                    ar_ready_i,
  output logic [31:0]            ar_addr_o,
  input  wire                    r_valid_i,
  output logic                   r_ready_o,
  input  wire  fetch_pkg::line_t r_data_i,
  input  wire  [1:0]             r_resp_i,
  line_queue_if.ctrl             q
);
  import fetch_pkg::*;

  fetch_state_e state;
  fetch_state_e state_d;
  tag_t         next_tag;
  tag_t         next_tag_d;
  tag_t         req_tag;
  tag_t         pc_tag;
  logic         discard;
  logic         discard_d;
  logic         ar_hs;
  logic         r_hs;
  logic         room;

  assign pc_tag = pc_i[31:OFFSET_BITS];
  assign ar_hs  = ar_valid_o && ar_ready_i;
  assign r_hs   = r_valid_i && r_ready_o;

  // a jump empties the queue on the next edge so there is room then
  assign room = jmp_flush_i || (q.count < LINE_DEPTH);

  // ====================================================================
  // state sequencing
  // ====================================================================
  always_comb begin
    state_d = state;
    case (state)
      FETCH_IDLE: begin
        if (room) begin
          state_d = FETCH_ADDR;
        end
      end
      FETCH_ADDR: begin
        if (ar_hs) begin
          state_d = FETCH_DATA;
        end
      end
      FETCH_DATA: begin
        // after a dropped beat the queue is empty, so refetch right away
        if (r_hs) begin
          state_d = (discard || jmp_flush_i) ? FETCH_ADDR : FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_comb begin
    if (jmp_flush_i) begin
      next_tag_d = pc_tag;
    end else if (r_hs && !discard) begin
      next_tag_d = next_tag + 1'b1;
    end else begin
      next_tag_d = next_tag;
    end
  end

  // the address already issued still gets its beat, which must be thrown away
  always_comb begin
    if (jmp_flush_i) begin
      discard_d = (state == FETCH_ADDR) || ((state == FETCH_DATA) && !r_hs);
    end else if (r_hs) begin
      discard_d = 1'b0;
    end else begin
      discard_d = discard;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state    <= FETCH_IDLE;
      next_tag <= RESET_PC[31:OFFSET_BITS];
      discard  <= 1'b0;
    end else begin
      state    <= state_d;
      next_tag <= next_tag_d;
      discard  <= discard_d;
    end
  end

  // held for the whole address phase
  always_ff @(posedge clk) begin
    if ((state_d == FETCH_ADDR) && (state != FETCH_ADDR)) begin
      req_tag <= next_tag_d;
    end
  end

  // ====================================================================
  // AXI read channels and queue write
  // ====================================================================
  assign ar_valid_o = (state == FETCH_ADDR);
  assign ar_addr_o  = {req_tag, {OFFSET_BITS{1'b0}}};
  assign r_ready_o  = (state == FETCH_DATA);

  assign q.push       = r_hs && !discard;
  assign q.push_entry = '{line: r_data_i, tag: req_tag, fault: |r_resp_i};
  assign q.flush      = jmp_flush_i;

endmodule

`default_nettype wire

// ==== line_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_queue #(
  parameter int LINE_DEPTH = 4
) (
  input  wire          clk,
  input  wire          rst_n,
  line_queue_if.queue  q
);
  import fetch_pkg::*;

  localparam int PTR_W = $clog2(LINE_DEPTH);

  // pointers carry one extra wrap bit
  logic [PTR_W:0]   wptr;
  logic [PTR_W:0]   rptr;
  logic [PTR_W-1:0] waddr;
  logic [PTR_W-1:0] raddr;

  q_entry_t mem [LINE_DEPTH];

  assign waddr = wptr[PTR_W-1:0];
  assign raddr = rptr[PTR_W-1:0];

  // ====================================================================
  // status
  // ====================================================================
  assign q.count = wptr - rptr;
  assign q.empty = (q.count == '0);
  assign q.full  = (q.count == LINE_DEPTH[PTR_W:0]);

  // ====================================================================
  // pointers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wptr <= '0;
    end else if (q.flush) begin
      // flush beats any push in the same cycle
      wptr <= '0;
    end else if (q.push) begin
      wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rptr <= '0;
    end else if (q.flush) begin
      rptr <= '0;
    end else if (q.pop) begin
      rptr <= rptr + 1'b1;
    end
  end

  // ====================================================================
  // storage
  // ====================================================================
  always_ff @(posedge clk) begin
    if (q.push) begin
      mem[waddr] <= q.push_entry;
    end
  end

  // write-to-read forward when the slot being written is the head
  always_comb begin
    if (q.push && (waddr == raddr)) begin
      q.head_entry = q.push_entry;
    end else begin
      q.head_entry = mem[raddr];
    end
  end

endmodule

`default_nettype wire

// ==== line_queue_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface line_queue_if #(
  parameter int LINE_DEPTH = 4
);
  import fetch_pkg::*;

  localparam int CNT_W = $clog2(LINE_DEPTH) + 1;

  // producer side
  logic     push;
  q_entry_t push_entry;
  logic     flush;

  // consumer side
  logic     pop;

  // queue status
  q_entry_t             head_entry;
  logic                 empty;
  logic                 full;
  logic [CNT_W-1:0]     count;

  modport ctrl (
    output push, push_entry, flush,
    input  count
  );

  modport queue (
    input  push, push_entry, flush, pop,
    output head_entry, empty, full, count
  );

  // push and push_entry are seen here for the empty-queue bypass
  modport select (
    input  head_entry, empty, push, push_entry,
    output pop
  );

endinterface

`default_nettype wire

// ==== tb_fetch_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_buffer;
  import fetch_pkg::*;

  localparam int          LINE_DEPTH    = 4;
  localparam logic [31:0] RESET_PC      = 32'h8000_0000;
  localparam logic [31:0] DATA_KEY      = 32'h5a5a_0f0f;
  localparam logic [31:0] FAULT_BASE    = 32'h8000_4000;
  localparam int unsigned RAND_SEED     = 32'h4653c599;
  localparam int          VALID_TIMEOUT = 200;
  localparam int          READ_TIMEOUT  = 100;
  localparam int          LONG_HOLD     = 64;
  localparam int          STALL_WINDOW  = 20;
  localparam logic [1:0]  JMP_NONE      = 2'd0;
  localparam logic [1:0]  JMP_NOW       = 2'd1;
  localparam logic [1:0]  JMP_INFLIGHT  = 2'd2;

  typedef struct packed {
    logic [31:0] pc;
    logic [1:0]  mode;
    logic        fault;
    int          hold;
  } row_t;

  logic               clk = 1'b0;
  logic               rst_n = 1'b1;
  logic [31:0]        pc_i = RESET_PC;
  logic               jmp_flush_i = 1'b0;
  logic               ar_ready_i = 1'b0;
  logic               r_valid_i = 1'b0;
  line_t              r_data_i = '0;
  logic [1:0]         r_resp_i = 2'b00;
  logic               inst_valid_o;
  logic [WORD_BITS:0] inst_o;
  logic               ar_valid_o;
  logic [31:0]        ar_addr_o;
  logic               r_ready_o;
  logic               exp_fault = 1'b0;
  logic               idle_expect = 1'b0;
  int                 check_count;
  int                 err_count;
  logic               read_pending = 1'b0;
  logic [31:0]        read_addr = '0;
  int                 ar_wait = 0;
  int                 r_wait = 0;
  row_t               stim[$];
  int                 timeouts = 0;
  int                 rows_failed = 0;

  always #50 clk = ~clk;

  fetch_buffer_top #(.LINE_DEPTH(LINE_DEPTH), .RESET_PC(RESET_PC)) dut_i (
    .clk(clk), .rst_n(rst_n), .pc_i(pc_i), .jmp_flush_i(jmp_flush_i),
    .inst_valid_o(inst_valid_o), .inst_o(inst_o),
    .ar_valid_o(ar_valid_o), .ar_ready_i(ar_ready_i), .ar_addr_o(ar_addr_o),
    .r_valid_i(r_valid_i), .r_ready_o(r_ready_o), .r_data_i(r_data_i), .r_resp_i(r_resp_i)
  );

  fetch_checker checker_i (
    .clk(clk), .rst_n(rst_n), .pc_i(pc_i), .inst_valid_i(inst_valid_o), .inst_i(inst_o),
    .ar_valid_i(ar_valid_o), .exp_fault_i(exp_fault), .idle_expect_i(idle_expect),
    .check_count_o(check_count), .err_count_o(err_count)
  );

  // ====================================================================
  // AXI memory model, 0 to 3 random wait cycles per channel
  // ====================================================================
  function automatic line_t line_for(input logic [31:0] addr);
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[i*32 +: 32] = (addr + 32'(4 * i)) ^ DATA_KEY;
    end
    return l;
  endfunction

  always @(posedge clk) begin
    if (rst_n) begin
      ar_ready_i   <= 1'b0;
      r_valid_i    <= 1'b0;
      read_pending <= 1'b0;
      ar_wait      <= 0;
      r_wait       <= 0;
    end else if (!read_pending) begin
      if (ar_valid_o && ar_ready_i) begin
        ar_ready_i   <= 1'b0;
        read_pending <= 1'b1;
        read_addr    <= ar_addr_o;
        r_wait       <= int'($urandom_range(3, 0));
      end else if (ar_wait > 0) begin
        ar_wait <= ar_wait - 1;
      end else begin
        ar_ready_i <= 1'b1;
      end
    end else if (r_valid_i && r_ready_o) begin
      r_valid_i    <= 1'b0;
      read_pending <= 1'b0;
      ar_wait      <= int'($urandom_range(3, 0));
    end else if (!r_valid_i) begin
      if (r_wait > 0) begin
        r_wait <= r_wait - 1;
      end else begin
        r_valid_i <= 1'b1;
        r_data_i  <= line_for(read_addr);
        r_resp_i  <= (read_addr >= FAULT_BASE) ? 2'b10 : 2'b00;
      end
    end
  end

  // ====================================================================
  // stimulus rows
  // ====================================================================
  task automatic add_row(input logic [31:0] pc, input logic [1:0] mode,
                         input logic fault, input int hold);
    row_t r;
    r = '{pc, mode, fault, hold};
    stim.push_back(r);
  endtask

  // stops at an edge whose cycle still had a read outstanding
  task automatic wait_read(output bit found);
    int n;
    found = 1'b0;
    n = 0;
    while (!found && n < READ_TIMEOUT) begin
      @(posedge clk);
      found = (ar_valid_o && !ar_ready_i) || (r_ready_o && !r_valid_i);
      n++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   errs_before;
    int   n;
    bit   read_seen;
    bit   got;
    r = stim[idx];
    errs_before = err_count;
    read_seen = 1'b1;
    if (r.mode == JMP_INFLIGHT) begin
      wait_read(read_seen);
    end else begin
      @(posedge clk);
    end
    pc_i        <= r.pc;
    exp_fault   <= r.fault;
    jmp_flush_i <= (r.mode != JMP_NONE);
    got = 1'b0;
    n = 0;
    while (!got && n < VALID_TIMEOUT) begin
      @(posedge clk);
      jmp_flush_i <= 1'b0;
      got = inst_valid_o;
      n++;
    end
    for (int k = 0; k < r.hold; k++) begin
      // long hold lets the queue fill, then requests must stop
      if (r.hold >= LONG_HOLD && k == r.hold - STALL_WINDOW) begin
        idle_expect <= 1'b1;
      end
      @(posedge clk);
    end
    idle_expect <= 1'b0;
    @(negedge clk);
    if (!read_seen) begin
      timeouts++;
      rows_failed++;
      $display("row %0d: timeout, no read in flight to jump over", idx);
    end else if (!got) begin
      timeouts++;
      rows_failed++;
      $display("row %0d: timeout, no valid instruction for pc %h", idx, r.pc);
    end else if (err_count != errs_before) begin
      rows_failed++;
      $display("row %0d pc %h: %0d errors", idx, r.pc, err_count - errs_before);
    end else begin
      $display("row %0d pc %h: ok, valid after %0d cycles", idx, r.pc, n);
    end
  endtask

  initial begin
    int asserts;
    void'($urandom(RAND_SEED));
    // pc, jump mode, fault, hold cycles
    add_row(32'h8000_0000, JMP_NONE,     1'b0, 2);
    add_row(32'h8000_0004, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0008, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_000c, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0010, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0014, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0018, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_001c, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0020, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0024, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0028, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_002c, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0030, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_0034, JMP_NONE,     1'b0, 1);
    add_row(32'h8000_1000, JMP_NOW,      1'b0, 80);
    add_row(32'h8000_1010, JMP_NONE,     1'b0, 1);
    add_row(32'h8000_1020, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_1030, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_1044, JMP_NONE,     1'b0, 1);
    add_row(32'h8000_3004, JMP_NOW,      1'b0, 0);
    add_row(32'h8000_2008, JMP_INFLIGHT, 1'b0, 2);
    add_row(32'h8000_2014, JMP_NONE,     1'b0, 0);
    add_row(32'h8000_4000, JMP_NOW,      1'b1, 2);
    add_row(32'h8000_4ff8, JMP_INFLIGHT, 1'b1, 0);
    add_row(32'h8000_5000, JMP_NONE,     1'b1, 0);
    add_row(32'h8000_3ff0, JMP_NOW,      1'b0, 1);
    add_row(32'h8000_4008, JMP_NONE,     1'b1, 2);
    repeat (10) @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < stim.size(); i++) begin
      run_row(i);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    asserts = dut_i.u_ctrl.props_i.fail_count;
    $display("rows %0d, rows failed %0d, timeouts %0d, checks %0d, errors %0d, assertions %0d",
             stim.size(), rows_failed, timeouts, check_count, err_count, asserts);
    if (rows_failed == 0 && err_count == 0 && asserts == 0 && check_count > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
